//--- source/sd_pkg.sv
package sd_pkg;

  // serial clock half periods in clk cycles at 100 MHz
  localparam logic [7:0] div_slow = 8'd125;
  localparam logic [7:0] div_fast = 8'd2;

  // slow clock periods with chip select high before CMD0
  localparam logic [6:0] powerup_sclk = 7'd80;

  // command indices
  localparam logic [5:0] cmd_go_idle         = 6'd0;
  localparam logic [5:0] cmd_send_if_cond    = 6'd8;
  localparam logic [5:0] cmd_read_ocr        = 6'd58;
  localparam logic [5:0] cmd_app_cmd         = 6'd55;
  localparam logic [5:0] cmd_sd_send_op_cond = 6'd41;
  localparam logic [5:0] cmd_set_blocklen    = 6'd16;

  // 2.7-3.6 V range plus check pattern
  localparam logic [31:0] arg_if_cond = 32'h0000_01AA;
  localparam logic [31:0] arg_hcs     = 32'h4000_0000;
  localparam logic [31:0] block_len   = 32'd512;

  localparam logic [7:0] r1_idle       = 8'h01;
  localparam logic [7:0] r1_ready      = 8'h00;
  localparam logic [7:0] r1_illegal    = 8'h05;
  localparam logic [7:0] check_pattern = 8'hAA;

  // response lengths in bits
  localparam logic [5:0] resp_len_r1 = 6'd8;
  localparam logic [5:0] resp_len_r7 = 6'd40;

  // sample edges allowed before the start bit
  localparam logic [6:0] resp_timeout = 7'd100;
  localparam logic [3:0] max_retries  = 4'd10;

  // command engine phases
  localparam logic [1:0] eng_idle = 2'd0;
  localparam logic [1:0] eng_send = 2'd1;
  localparam logic [1:0] eng_hunt = 2'd2;
  localparam logic [1:0] eng_recv = 2'd3;

  // init sequence steps
  localparam logic [3:0] st_powerup = 4'd0;
  localparam logic [3:0] st_cmd0    = 4'd1;
  localparam logic [3:0] st_cmd8    = 4'd2;
  localparam logic [3:0] st_ocr1    = 4'd3;
  localparam logic [3:0] st_cmd55   = 4'd4;
  localparam logic [3:0] st_acmd41  = 4'd5;
  localparam logic [3:0] st_ocr2    = 4'd6;
  localparam logic [3:0] st_cmd16   = 4'd7;
  localparam logic [3:0] st_done    = 4'd8;
  localparam logic [3:0] st_error   = 4'd9;

  // R1-only replies land in the top byte
  typedef union packed {
    struct packed {
      logic [7:0]  r1;
      logic [19:0] reserved;
      logic [3:0]  voltage;
      logic [7:0]  echo;
    } r7;
    struct packed {
      logic [7:0]  r1;
      logic [31:0] ocr;
    } r3;
  } sd_resp_u;

endpackage

//--- source/uart_pkg.sv
package uart_pkg;

  // 100 MHz / 115200 baud
  localparam logic [9:0] clk_per_bit = 10'd868;

  // trace characters held before the transmitter
  localparam int log_depth = 256;

  localparam logic [7:0] ch_send    = "s";
  localparam logic [7:0] ch_resp    = "r";
  localparam logic [7:0] ch_timeout = "e";

endpackage

//--- source/sd_clock_gen.sv
`timescale 1ns/1ps

module sd_clock_gen (
  input  logic clk,
  input  logic rst,
  input  logic sclk_run,
  input  logic fast_clk,
  output logic sd_sclk,
  output logic shift_edge,
  output logic sample_edge
);

  logic [7:0] cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      sd_sclk <= 1'b0;
      cnt <= 8'd0;
      shift_edge <= 1'b0;
      sample_edge <= 1'b0;
    end else begin
      shift_edge <= 1'b0;
      sample_edge <= 1'b0;
      if (!sclk_run) begin
        sd_sclk <= 1'b0;
        cnt <= 8'd0;
      end else if (cnt == 8'd0) begin
        // divider is picked up only here, so a speed change never cuts a half period
        cnt <= (fast_clk ? sd_pkg::div_fast : sd_pkg::div_slow) - 8'd1;
        sd_sclk <= !sd_sclk;
        shift_edge <= sd_sclk;
        sample_edge <= !sd_sclk;
      end else begin
        cnt <= cnt - 8'd1;
      end
    end
  end

  // strobes at least two clk apart, even on the fast divider
  a_edges_apart: assert property (@(posedge clk) disable iff (rst)
    (shift_edge || sample_edge) |=> !(shift_edge || sample_edge));

endmodule

//--- source/sd_cmd_engine.sv
`timescale 1ns/1ps

module sd_cmd_engine (
  input  logic            clk,
  input  logic            rst,
  input  logic            shift_edge,
  input  logic            sample_edge,
  input  logic            cmd_start,
  input  logic [5:0]      cmd_index,
  input  logic [31:0]     cmd_arg,
  input  logic [5:0]      resp_bits,
  input  logic            sd_miso,
  output logic            sd_mosi,
  output logic            cmd_busy,
  output logic            cmd_done,
  output sd_pkg::sd_resp_u resp,
  output logic            resp_timeout
);

  logic [1:0]  state;
  logic [47:0] frame;
  logic [6:0]  crc;
  logic [6:0]  crc_next;
  logic        fb;
  logic [5:0]  bit_cnt;
  logic [5:0]  resp_len;
  logic [6:0]  wait_cnt;

  assign cmd_busy = state != sd_pkg::eng_idle;

  // crc7, x^7 + x^3 + 1, fed with the bit going out now
  assign fb = crc[6] ^ frame[47];
  assign crc_next = {crc[5:3], crc[2] ^ fb, crc[1:0], fb};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= sd_pkg::eng_idle;
      sd_mosi <= 1'b1;
      cmd_done <= 1'b0;
      resp_timeout <= 1'b0;
    end else begin
      cmd_done <= 1'b0;
      case (state)
        sd_pkg::eng_idle: begin
          if (cmd_start) begin
            state <= sd_pkg::eng_send;
            resp_timeout <= 1'b0;
          end
        end
        sd_pkg::eng_send: begin
          if (shift_edge) begin
            sd_mosi <= frame[47];
            if (bit_cnt == 6'd47) begin
              state <= sd_pkg::eng_hunt;
            end
          end
        end
        sd_pkg::eng_hunt: begin
          // keep MOSI high while the card prepares its answer
          if (shift_edge) begin
            sd_mosi <= 1'b1;
          end
          if (sample_edge) begin
            if (!sd_miso) begin
              state <= sd_pkg::eng_recv;
            end else if (wait_cnt == sd_pkg::resp_timeout - 7'd1) begin
              state <= sd_pkg::eng_idle;
              cmd_done <= 1'b1;
              resp_timeout <= 1'b1;
            end
          end
        end
        default: begin
          if (shift_edge) begin
            sd_mosi <= 1'b1;
          end
          if (sample_edge && bit_cnt == resp_len - 6'd1) begin
            state <= sd_pkg::eng_idle;
            cmd_done <= 1'b1;
          end
        end
      endcase
    end
  end

  // frame, crc and response shift registers
  always_ff @(posedge clk) begin
    if (state == sd_pkg::eng_idle && cmd_start) begin
      // crc slot left zero, end bit set
      frame <= {2'b01, cmd_index, cmd_arg, 8'h01};
      crc <= 7'd0;
      bit_cnt <= 6'd0;
      resp_len <= resp_bits;
      wait_cnt <= 7'd0;
      resp <= '0;
    end else if (state == sd_pkg::eng_send && shift_edge) begin
      bit_cnt <= bit_cnt + 6'd1;
      if (bit_cnt < 6'd40) begin
        crc <= crc_next;
      end
      if (bit_cnt == 6'd39) begin
        frame <= {crc_next, 1'b1, 40'hFF_FFFF_FFFF};
      end else begin
        frame <= {frame[46:0], 1'b1};
      end
    end else if (state == sd_pkg::eng_hunt && sample_edge) begin
      wait_cnt <= wait_cnt + 7'd1;
      // start bit is the r1 msb, already zero
      bit_cnt <= 6'd1;
    end else if (state == sd_pkg::eng_recv && sample_edge) begin
      resp[6'd39 - bit_cnt] <= sd_miso;
      bit_cnt <= bit_cnt + 6'd1;
    end
  end

  a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
    cmd_start |-> !cmd_busy);

endmodule

//--- source/sd_init_fsm.sv
`timescale 1ns/1ps

module sd_init_fsm (
  input  logic             clk,
  input  logic             rst,
  input  logic             shift_edge,
  input  logic             cmd_busy,
  input  logic             cmd_done,
  input  sd_pkg::sd_resp_u resp,
  input  logic             resp_timeout,
  output logic             sclk_run,
  output logic             fast_clk,
  output logic             sd_cs,
  output logic             cmd_start,
  output logic [5:0]       cmd_index,
  output logic [31:0]      cmd_arg,
  output logic [5:0]       resp_bits,
  output logic             init_done,
  output logic             init_error,
  output logic             high_capacity
);

  logic [3:0] step;
  logic       waiting;
  logic [6:0] pu_cnt;
  logic [3:0] retries;
  logic [7:0] r1;
  logic       last_try;

  assign r1 = resp.r7.r1;
  assign last_try = retries == sd_pkg::max_retries - 4'd1;

  // command for the current step, held stable while it is in flight
  always_comb begin
    cmd_index = sd_pkg::cmd_go_idle;
    cmd_arg = 32'd0;
    resp_bits = sd_pkg::resp_len_r1;
    case (step)
      sd_pkg::st_cmd8: begin
        cmd_index = sd_pkg::cmd_send_if_cond;
        cmd_arg = sd_pkg::arg_if_cond;
        resp_bits = sd_pkg::resp_len_r7;
      end
      sd_pkg::st_ocr1, sd_pkg::st_ocr2: begin
        cmd_index = sd_pkg::cmd_read_ocr;
        resp_bits = sd_pkg::resp_len_r7;
      end
      sd_pkg::st_cmd55: cmd_index = sd_pkg::cmd_app_cmd;
      sd_pkg::st_acmd41: begin
        cmd_index = sd_pkg::cmd_sd_send_op_cond;
        cmd_arg = sd_pkg::arg_hcs;
      end
      sd_pkg::st_cmd16: begin
        cmd_index = sd_pkg::cmd_set_blocklen;
        cmd_arg = sd_pkg::block_len;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      step <= sd_pkg::st_powerup;
      waiting <= 1'b0;
      pu_cnt <= 7'd0;
      retries <= 4'd0;
      sclk_run <= 1'b0;
      fast_clk <= 1'b0;
      sd_cs <= 1'b1;
      cmd_start <= 1'b0;
      init_done <= 1'b0;
      init_error <= 1'b0;
      high_capacity <= 1'b0;
    end else begin
      cmd_start <= 1'b0;
      case (step)
        sd_pkg::st_powerup: begin
          sclk_run <= 1'b1;
          if (shift_edge) begin
            pu_cnt <= pu_cnt + 7'd1;
            if (pu_cnt == sd_pkg::powerup_sclk - 7'd1) begin
              sd_cs <= 1'b0;
              step <= sd_pkg::st_cmd0;
            end
          end
        end
        sd_pkg::st_done, sd_pkg::st_error: begin
          init_done <= step == sd_pkg::st_done;
          init_error <= step == sd_pkg::st_error;
          sclk_run <= 1'b0;
          sd_cs <= 1'b1;
        end
        default: begin
          if (!waiting) begin
            if (!cmd_busy) begin
              cmd_start <= 1'b1;
              waiting <= 1'b1;
            end
          end else if (cmd_done) begin
            waiting <= 1'b0;
            // only CMD0 may retry after silence
            if (resp_timeout && step != sd_pkg::st_cmd0) begin
              step <= sd_pkg::st_error;
            end else begin
              case (step)
                sd_pkg::st_cmd0: begin
                  if (resp_timeout || r1 != sd_pkg::r1_idle) begin
                    if (last_try) step <= sd_pkg::st_error;
                    else retries <= retries + 4'd1;
                  end else begin
                    retries <= 4'd0;
                    step <= sd_pkg::st_cmd8;
                  end
                end
                sd_pkg::st_cmd8: begin
                  // v1 cards reject CMD8, v2 cards echo the pattern
                  if (r1 == sd_pkg::r1_illegal || (r1 == sd_pkg::r1_idle &&
                      resp.r7.voltage == 4'h1 && resp.r7.echo == sd_pkg::check_pattern))
                    step <= sd_pkg::st_ocr1;
                  else
                    step <= sd_pkg::st_error;
                end
                sd_pkg::st_ocr1: step <= sd_pkg::st_cmd55;
                sd_pkg::st_cmd55: step <= sd_pkg::st_acmd41;
                sd_pkg::st_acmd41: begin
                  if (r1 == sd_pkg::r1_idle) begin
                    if (last_try) begin
                      step <= sd_pkg::st_error;
                    end else begin
                      retries <= retries + 4'd1;
                      step <= sd_pkg::st_cmd55;
                    end
                  end else begin
                    step <= (r1 == sd_pkg::r1_ready) ? sd_pkg::st_ocr2 : sd_pkg::st_error;
                  end
                end
                sd_pkg::st_ocr2: begin
                  // ccs bit, valid once the card is ready
                  high_capacity <= resp.r3.ocr[30];
                  fast_clk <= 1'b1;
                  step <= sd_pkg::st_cmd16;
                end
                default: begin
                  step <= (r1 == sd_pkg::r1_ready) ? sd_pkg::st_done : sd_pkg::st_error;
                end
              endcase
            end
          end
        end
      endcase
    end
  end

endmodule

//--- source/debug_log.sv
`timescale 1ns/1ps

module debug_log (
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_start,
  input  logic       cmd_done,
  input  logic       resp_timeout,
  input  logic [7:0] resp_byte,
  input  logic       tx_busy,
  output logic       tx_start,
  output logic [7:0] tx_data
);

  localparam int aw = $clog2(uart_pkg::log_depth);

  logic [7:0]  mem [uart_pkg::log_depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [aw:0] count;
  logic        full;
  logic        wr_en;
  logic        pop;
  // up to five characters waiting, head in the top byte
  logic [39:0] pend;
  logic [39:0] pend_d;
  logic [2:0]  pend_cnt;
  logic [2:0]  cnt_d;

  function automatic logic [7:0] hex_char(input logic [3:0] n);
    return (n < 4'd10) ? 8'h30 + {4'h0, n} : 8'h37 + {4'h0, n};
  endfunction

  assign full = count == uart_pkg::log_depth;
  assign wr_en = pend_cnt != 3'd0;
  assign pop = !tx_busy && !tx_start && count != '0;

  always_comb begin
    pend_d = pend;
    cnt_d = pend_cnt;
    if (pend_cnt != 3'd0) begin
      pend_d = {pend[31:0], 8'h00};
      cnt_d = pend_cnt - 3'd1;
    end
    if (cmd_start) begin
      pend_d[39 - 8 * cnt_d -: 8] = uart_pkg::ch_send;
      cnt_d = cnt_d + 3'd1;
    end
    if (cmd_done) begin
      if (resp_timeout) begin
        pend_d[39 - 8 * cnt_d -: 8] = uart_pkg::ch_timeout;
        cnt_d = cnt_d + 3'd1;
      end
      pend_d[39 - 8 * cnt_d -: 8] = uart_pkg::ch_resp;
      pend_d[31 - 8 * cnt_d -: 8] = hex_char(resp_byte[7:4]);
      pend_d[23 - 8 * cnt_d -: 8] = hex_char(resp_byte[3:0]);
      cnt_d = cnt_d + 3'd3;
    end
  end

  always_ff @(posedge clk) begin
    pend <= pend_d;
    if (wr_en && !full) begin
      mem[wr_ptr] <= pend[39:32];
    end
    if (pop) begin
      tx_data <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_cnt <= 3'd0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      tx_start <= 1'b0;
    end else begin
      pend_cnt <= cnt_d;
      tx_start <= pop;
      if (wr_en && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if ((wr_en && !full) && !pop) count <= count + 1'b1;
      else if (pop && !(wr_en && !full)) count <= count - 1'b1;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full);

endmodule

//--- source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
  input  logic       clk,
  input  logic       rst,
  input  logic       tx_start,
  input  logic [7:0] tx_data,
  output logic       tx_busy,
  output logic       uart_txd
);

  // stop, data lsb first, start; bit 0 is on the line
  logic [9:0] shreg;
  logic [9:0] baud_cnt;
  logic [3:0] bit_cnt;

  assign uart_txd = shreg[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      shreg <= 10'h3FF;
      baud_cnt <= 10'd0;
      bit_cnt <= 4'd0;
      tx_busy <= 1'b0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        shreg <= {1'b1, tx_data, 1'b0};
        baud_cnt <= 10'd0;
        bit_cnt <= 4'd0;
        tx_busy <= 1'b1;
      end
    end else if (baud_cnt == uart_pkg::clk_per_bit - 10'd1) begin
      baud_cnt <= 10'd0;
      shreg <= {1'b1, shreg[9:1]};
      bit_cnt <= bit_cnt + 4'd1;
      // stop bit has just run its full length
      if (bit_cnt == 4'd9) begin
        tx_busy <= 1'b0;
      end
    end else begin
      baud_cnt <= baud_cnt + 10'd1;
    end
  end

endmodule

//--- source/sd_spi_init.sv
`timescale 1ns/1ps

module sd_spi_init (
  input  logic clk,
  input  logic rst,
  output logic sd_sclk,
  output logic sd_mosi,
  input  logic sd_miso,
  output logic sd_cs,
  output logic uart_txd,
  output logic init_done,
  output logic init_error,
  output logic high_capacity
);

  logic             sclk_run;
  logic             fast_clk;
  logic             shift_edge;
  logic             sample_edge;
  logic             cmd_start;
  logic [5:0]       cmd_index;
  logic [31:0]      cmd_arg;
  logic [5:0]       resp_bits;
  logic             cmd_busy;
  logic             cmd_done;
  sd_pkg::sd_resp_u resp;
  logic             resp_timeout;
  logic             tx_start;
  logic [7:0]       tx_data;
  logic             tx_busy;

  sd_clock_gen u_clock_gen (
    .clk(clk), .rst(rst), .sclk_run(sclk_run), .fast_clk(fast_clk),
    .sd_sclk(sd_sclk), .shift_edge(shift_edge), .sample_edge(sample_edge)
  );

  sd_cmd_engine u_cmd_engine (
    .clk(clk), .rst(rst), .shift_edge(shift_edge), .sample_edge(sample_edge),
    .cmd_start(cmd_start), .cmd_index(cmd_index), .cmd_arg(cmd_arg),
    .resp_bits(resp_bits), .sd_miso(sd_miso), .sd_mosi(sd_mosi),
    .cmd_busy(cmd_busy), .cmd_done(cmd_done), .resp(resp), .resp_timeout(resp_timeout)
  );

  sd_init_fsm u_init_fsm (
    .clk(clk), .rst(rst), .shift_edge(shift_edge), .cmd_busy(cmd_busy),
    .cmd_done(cmd_done), .resp(resp), .resp_timeout(resp_timeout),
    .sclk_run(sclk_run), .fast_clk(fast_clk), .sd_cs(sd_cs), .cmd_start(cmd_start),
    .cmd_index(cmd_index), .cmd_arg(cmd_arg), .resp_bits(resp_bits),
    .init_done(init_done), .init_error(init_error), .high_capacity(high_capacity)
  );

  // trace taps the engine handshake directly
  debug_log u_debug_log (
    .clk(clk), .rst(rst), .cmd_start(cmd_start), .cmd_done(cmd_done),
    .resp_timeout(resp_timeout), .resp_byte(resp.r7.r1), .tx_busy(tx_busy),
    .tx_start(tx_start), .tx_data(tx_data)
  );

  uart_tx u_uart_tx (
    .clk(clk), .rst(rst), .tx_start(tx_start), .tx_data(tx_data),
    .tx_busy(tx_busy), .uart_txd(uart_txd)
  );

endmodule

//--- tests/sd_card_model.sv
`timescale 1ns/1ps

module sd_card_model (
  input  logic        clk,
  input  logic        rst,
  input  logic        sd_sclk,
  input  logic        sd_cs,
  input  logic        sd_mosi,
  output logic        sd_miso,
  input  logic [1:0]  silent_cnt,
  input  logic [3:0]  nonidle_cnt,
  input  logic [1:0]  cmd8_mode,
  input  logic [3:0]  idle_cnt,
  input  logic        ccs,
  input  logic        reject16,
  output logic        frame_valid,
  output logic        frame_ok,
  output logic [5:0]  frame_index,
  output logic [31:0] frame_arg,
  output logic [7:0]  frame_high
);

  logic        sclk_q;
  logic        in_frame;
  logic [47:0] rx;
  logic [5:0]  rx_cnt;
  logic [39:0] tx;
  logic [5:0]  tx_left;
  logic [1:0]  gap;
  logic [7:0]  high_cnt;
  logic [7:0]  high_min;
  int          cmd0_seen;
  int          acmd_seen;
  logic        app;
  logic        ready;

  initial sd_miso = 1'b1;

  // polynomial x^7 + x^3 + 1 over start bits, index and argument
  function automatic logic [6:0] crc7(input logic [39:0] d);
    logic [6:0] c;
    c = 7'd0;
    for (int i = 39; i >= 0; i--) begin
      c = {c[5:0], 1'b0} ^ ((c[6] ^ d[i]) ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  task automatic answer(input logic [47:0] f);
    frame_valid <= 1'b1;
    frame_ok <= (f[47:46] == 2'b01) && f[0] && (f[7:1] == crc7(f[47:8]));
    frame_index <= f[45:40];
    frame_arg <= f[39:8];
    frame_high <= high_min;
    gap <= 2'd2;
    tx_left <= 6'd8;
    app <= 1'b0;
    case (f[45:40])
      6'd0: begin
        cmd0_seen <= cmd0_seen + 1;
        if (cmd0_seen < silent_cnt) tx_left <= 6'd0;
        tx <= {(cmd0_seen < silent_cnt + nonidle_cnt) ? 8'h00 : 8'h01, 32'd0};
      end
      6'd8: begin
        tx_left <= 6'd40;
        case (cmd8_mode)
          2'd2: tx <= {8'h05, 32'd0};
          2'd3: tx <= {8'h01, 24'h000001, 8'h55};
          // echo voltage and check pattern back
          default: tx <= {8'h01, 20'd0, f[19:8]};
        endcase
      end
      6'd58: begin
        tx_left <= 6'd40;
        tx <= {ready ? 8'h00 : 8'h01, ready, ccs, 6'd0, 24'hFF8000};
      end
      6'd55: begin
        app <= 1'b1;
        tx <= {ready ? 8'h00 : 8'h01, 32'd0};
      end
      6'd41: begin
        if (!app) begin
          tx <= {8'h04, 32'd0};
        end else begin
          acmd_seen <= acmd_seen + 1;
          ready <= acmd_seen >= idle_cnt;
          tx <= {(acmd_seen >= idle_cnt) ? 8'h00 : 8'h01, 32'd0};
        end
      end
      6'd16: tx <= {reject16 ? 8'h40 : 8'h00, 32'd0};
      default: tx <= {8'h04, 32'd0};
    endcase
  endtask

  always @(posedge clk) begin
    if (rst) begin
      sclk_q <= 1'b0;
      in_frame <= 1'b0;
      rx_cnt <= 6'd0;
      tx_left <= 6'd0;
      gap <= 2'd0;
      sd_miso <= 1'b1;
      frame_valid <= 1'b0;
      high_cnt <= 8'd0;
      cmd0_seen <= 0;
      acmd_seen <= 0;
      app <= 1'b0;
      ready <= 1'b0;
    end else begin
      sclk_q <= sd_sclk;
      frame_valid <= 1'b0;
      high_cnt <= sd_sclk ? high_cnt + 8'd1 : 8'd0;
      // mosi sampled on the rising edge
      if (sd_sclk && !sclk_q && !sd_cs) begin
        if (!in_frame && !sd_mosi) begin
          in_frame <= 1'b1;
          rx <= 48'd0;
          rx_cnt <= 6'd1;
          high_min <= 8'hFF;
        end else if (in_frame) begin
          rx <= {rx[46:0], sd_mosi};
          rx_cnt <= rx_cnt + 6'd1;
          if (rx_cnt == 6'd47) begin
            in_frame <= 1'b0;
            answer({rx[46:0], sd_mosi});
          end
        end
      end
      // miso changes on the falling edge
      if (!sd_sclk && sclk_q) begin
        if (in_frame && high_cnt < high_min) high_min <= high_cnt;
        if (gap != 2'd0) begin
          gap <= gap - 2'd1;
        end else if (tx_left != 6'd0) begin
          sd_miso <= tx[39];
          tx <= {tx[38:0], 1'b1};
          tx_left <= tx_left - 6'd1;
        end else begin
          sd_miso <= 1'b1;
        end
      end
    end
  end

endmodule

//--- tests/tb_sd_spi_init.sv
`timescale 1ns/1ps

module tb_sd_spi_init;

  localparam int trials = 8;
  localparam int bit_clks = uart_pkg::clk_per_bit;
  // ten CMD0, CMD8, two CMD58, ten CMD55/ACMD41 pairs, CMD16, plus power-up
  localparam longint worst_cmds = 35;
  // 48 frame bits, 100 edges of timeout and 40 response bits, rounded up
  localparam longint frame_ns = 200 * 2 * sd_pkg::div_slow * 8;
  // up to five trace characters per command
  localparam longint drain_ns = worst_cmds * 5 * 10 * bit_clks * 8;
  localparam longint watchdog_ns = trials * (worst_cmds * frame_ns + drain_ns);

  logic clk;
  logic rst;
  logic sd_sclk, sd_mosi, sd_miso, sd_cs, uart_txd;
  logic init_done, init_error, high_capacity;

  // card personality
  logic [1:0] silent_cnt;
  logic [3:0] nonidle_cnt;
  logic [1:0] cmd8_mode;
  logic [3:0] idle_cnt;
  logic       ccs;
  logic       reject16;

  logic        frame_valid, frame_ok;
  logic [5:0]  frame_index;
  logic [31:0] frame_arg;
  logic [7:0]  frame_high;

  integer      seed;
  logic [5:0]  exp_index[$];
  logic [31:0] exp_arg[$];
  logic [7:0]  exp_trace[$];
  logic [7:0]  rx_trace[$];
  logic        exp_done;
  logic        exp_hc;
  int          fast_from;
  int          frame_num;
  int          cs_rises;
  logic        powerup_checked;
  logic [7:0]  slow_high;
  logic        sclk_q;
  logic        rx_busy;

  sd_spi_init UUT (
    .clk(clk), .rst(rst), .sd_sclk(sd_sclk), .sd_mosi(sd_mosi), .sd_miso(sd_miso),
    .sd_cs(sd_cs), .uart_txd(uart_txd), .init_done(init_done), .init_error(init_error),
    .high_capacity(high_capacity)
  );

  sd_card_model card (
    .clk(clk), .rst(rst), .sd_sclk(sd_sclk), .sd_cs(sd_cs), .sd_mosi(sd_mosi),
    .sd_miso(sd_miso), .silent_cnt(silent_cnt), .nonidle_cnt(nonidle_cnt),
    .cmd8_mode(cmd8_mode), .idle_cnt(idle_cnt), .ccs(ccs), .reject16(reject16),
    .frame_valid(frame_valid), .frame_ok(frame_ok), .frame_index(frame_index),
    .frame_arg(frame_arg), .frame_high(frame_high)
  );

  task automatic expect_equal(input string name, input longint expected, input longint actual);
    if (expected != actual) begin
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  function automatic logic [7:0] hex_digit(input logic [3:0] n);
    return (n < 4'd10) ? "0" + n : "A" + n - 4'd10;
  endfunction

  task automatic add_command(input logic [5:0] idx, input logic [31:0] arg,
                             input logic [7:0] r1, input logic timed_out);
    exp_index.push_back(idx);
    exp_arg.push_back(arg);
    exp_trace.push_back("s");
    if (timed_out) exp_trace.push_back("e");
    exp_trace.push_back("r");
    exp_trace.push_back(hex_digit(r1[7:4]));
    exp_trace.push_back(hex_digit(r1[3:0]));
  endtask

  // expected frames, trace and outcome for the current personality
  task automatic predict();
    int   tries;
    logic ok;
    exp_index.delete();
    exp_arg.delete();
    exp_trace.delete();
    exp_done = 1'b0;
    exp_hc = 1'b0;
    fast_from = 1000;
    ok = 1'b0;
    tries = 0;
    while (!ok && tries < sd_pkg::max_retries) begin
      if (tries < silent_cnt) add_command(6'd0, 32'd0, 8'h00, 1'b1);
      else if (tries < silent_cnt + nonidle_cnt) add_command(6'd0, 32'd0, 8'h00, 1'b0);
      else ok = 1'b1;
      if (ok) add_command(6'd0, 32'd0, 8'h01, 1'b0);
      tries++;
    end
    if (!ok) return;
    add_command(6'd8, 32'h1AA, (cmd8_mode == 2'd2) ? 8'h05 : 8'h01, 1'b0);
    if (cmd8_mode == 2'd3) return;
    add_command(6'd58, 32'd0, 8'h01, 1'b0);
    ok = 1'b0;
    tries = 0;
    while (!ok && tries < sd_pkg::max_retries) begin
      add_command(6'd55, 32'd0, 8'h01, 1'b0);
      ok = tries >= idle_cnt;
      add_command(6'd41, 32'h4000_0000, ok ? 8'h00 : 8'h01, 1'b0);
      tries++;
    end
    if (!ok) return;
    add_command(6'd58, 32'd0, 8'h00, 1'b0);
    exp_hc = ccs;
    fast_from = exp_index.size();
    add_command(6'd16, 32'd512, reject16 ? 8'h40 : 8'h00, 1'b0);
    exp_done = !reject16;
  endtask

  // power-up and frame monitor
  always @(posedge clk) begin
    sclk_q <= sd_sclk;
    if (rst) begin
      frame_num <= 0;
      cs_rises <= 0;
      powerup_checked <= 1'b0;
    end else begin
      if (!powerup_checked && !sd_cs) begin
        expect_equal("sclk periods with cs high", 80, (cs_rises >= 80) ? 80 : cs_rises);
        powerup_checked <= 1'b1;
      end else if (!powerup_checked && sd_sclk && !sclk_q) begin
        cs_rises <= cs_rises + 1;
      end
      if (frame_valid) begin
        expect_equal("frame within expected count", 1, frame_num < exp_index.size());
        expect_equal($sformatf("frame %0d framing and crc", frame_num), 1, frame_ok);
        expect_equal($sformatf("frame %0d index", frame_num), exp_index[frame_num], frame_index);
        expect_equal($sformatf("frame %0d argument", frame_num), exp_arg[frame_num], frame_arg);
        if (frame_num == 0) begin
          slow_high <= frame_high;
        end else if (frame_num >= fast_from) begin
          expect_equal("fast sclk after second CMD58", 1, frame_high < slow_high);
        end else begin
          expect_equal("slow sclk before second CMD58", slow_high, frame_high);
        end
        frame_num <= frame_num + 1;
      end
    end
  end

  // uart receiver, samples mid-bit
  initial begin
    logic [7:0] b;
    rx_busy = 1'b0;
    forever begin
      @(posedge clk);
      if (!rst && !uart_txd) begin
        rx_busy = 1'b1;
        repeat (bit_clks / 2) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (bit_clks) @(posedge clk);
          b[i] = uart_txd;
        end
        repeat (bit_clks) @(posedge clk);
        expect_equal("uart stop bit", 1, uart_txd);
        rx_trace.push_back(b);
        rx_busy = 1'b0;
      end
    end
  end

  task automatic run_trial(input int t);
    int idle;
    @(posedge clk);
    rst <= 1'b1;
    // first two trials force the CMD0 and ACMD41 retry limits
    silent_cnt <= 2'({$random(seed)} % 3);
    nonidle_cnt <= (t == 0) ? 4'd10 : (t == 1) ? 4'd0 : 4'({$random(seed)} % 4);
    cmd8_mode <= (t == 1) ? 2'd0 : 2'({$random(seed)} % 4);
    idle_cnt <= (t == 1) ? 4'd12 : 4'({$random(seed)} % 13);
    ccs <= 1'($random(seed));
    reject16 <= ({$random(seed)} % 4) == 0;
    repeat (10) @(posedge clk);
    predict();
    rx_trace.delete();
    $display("trial %0d: silent %0d non-idle %0d cmd8 %0d idle %0d ccs %0d reject16 %0d",
             t, silent_cnt, nonidle_cnt, cmd8_mode, idle_cnt, ccs, reject16);
    rst <= 1'b0;
    while (!init_done && !init_error) @(posedge clk);
    expect_equal("init_done", exp_done, init_done);
    expect_equal("init_error", !exp_done, init_error);
    expect_equal("high_capacity", exp_hc, high_capacity);
    // drained once the line has been idle for two characters
    idle = 0;
    while (idle < 20 * bit_clks) begin
      @(posedge clk);
      idle = (rx_busy || !uart_txd) ? 0 : idle + 1;
    end
    expect_equal("init_done held", exp_done, init_done);
    expect_equal("init_error held", !exp_done, init_error);
    expect_equal("frame count", exp_index.size(), frame_num);
    expect_equal("trace length", exp_trace.size(), rx_trace.size());
    for (int i = 0; i < exp_trace.size(); i++) begin
      expect_equal($sformatf("trace char %0d", i), exp_trace[i], rx_trace[i]);
    end
    $display("trial %0d: %s after %0d commands", t, init_done ? "done" : "error", frame_num);
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns before all trials finished", watchdog_ns);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    seed = 32'h68e8ed56;
    rst = 1'b1;
    silent_cnt = 2'd0;
    nonidle_cnt = 4'd0;
    cmd8_mode = 2'd0;
    idle_cnt = 4'd0;
    ccs = 1'b0;
    reject16 = 1'b0;
    for (int t = 0; t < trials; t++) begin
      run_trial(t);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- sd_spi_init.f
source/sd_pkg.sv
source/uart_pkg.sv
source/sd_clock_gen.sv
source/sd_cmd_engine.sv
source/sd_init_fsm.sv
source/debug_log.sv
source/uart_tx.sv
source/sd_spi_init.sv
tests/sd_card_model.sv
tests/tb_sd_spi_init.sv

//--- Makefile
# Verilator build and run for the SD SPI init core
VERILATOR ?= verilator
TOP       ?= tb_sd_spi_init
FILELIST  ?= sd_spi_init.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= SIMULATION PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
